//--- compile.f
hw/ipod_pkg.sv
hw/flash_fetch.sv
hw/sample_fifo.sv
hw/rate_control.sv
hw/sample_player.sv
hw/ipod_top.sv
tb/tb_ipod_asserts.sv
tb/tb_ipod.sv

//--- hw/flash_fetch.sv
`timescale 1ns/1ps

module flash_fetch (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic                          play,
  input  logic                          direction,
  input  logic                          restart,
  output ipod_pkg::flash_req_t          flash_req,
  input  ipod_pkg::flash_rsp_t          flash_rsp,
  input  logic                          word_room,
  output logic                          push,
  output logic [ipod_pkg::sample_w-1:0] push_sample
);

  import ipod_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data,
    st_second_push
  } fetch_state_t;

  fetch_state_t            state;
  logic [flash_addr_w-1:0] addr;
  logic [flash_addr_w-1:0] addr_next;
  logic                    restart_pending;
  logic                    restart_hit;
  logic                    data_take;
  logic [sample_w-1:0]     lower_half;
  logic [sample_w-1:0]     upper_half;
  logic [sample_w-1:0]     held_half;
  logic                    held_dir;

  assign lower_half  = flash_rsp.readdata[sample_w-1:0];
  assign upper_half  = flash_rsp.readdata[flash_data_w-1:sample_w];
  assign restart_hit = restart | restart_pending;

  // Data from a read issued before a restart is thrown away
  assign data_take = (state == st_wait_data) && flash_rsp.readdatavalid && !restart_hit;

  // Backward order sends the upper half first
  assign push        = data_take || (state == st_second_push);
  assign push_sample = (state == st_second_push) ? held_half :
                       (direction ? upper_half : lower_half);

  assign flash_req.read    = (state == st_request);
  assign flash_req.address = addr;

  // Word step with wrap at both ends of the song
  always_comb
  begin
    if (held_dir)
      addr_next = (addr == '0) ? song_last_word : addr - 1'b1;
    else
      addr_next = (addr == song_last_word) ? '0 : addr + 1'b1;
  end

  // ==============================
  // Fetch FSM
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state           <= st_idle;
      addr            <= '0;
      restart_pending <= 1'b0;
    end
    else
    begin
      if (restart)
        restart_pending <= 1'b1;
      case (state)
        st_idle:
        begin
          // Nothing outstanding, so a restart lands here
          if (restart_hit)
          begin
            addr            <= direction ? song_last_word : '0;
            restart_pending <= 1'b0;
          end
          else if (play && word_room)
            state <= st_request;
        end
        st_request:
        begin
          // Held until the port takes it
          if (!flash_rsp.waitrequest)
            state <= st_wait_data;
        end
        st_wait_data:
        begin
          if (flash_rsp.readdatavalid)
            state <= restart_hit ? st_idle : st_second_push;
        end
        st_second_push:
        begin
          addr  <= addr_next;
          state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // Second half of the word and the order it came in
  always_ff @(posedge CLK_50M)
  begin
    if (data_take)
    begin
      held_half <= direction ? lower_half : upper_half;
      held_dir  <= direction;
    end
  end

endmodule

//--- hw/ipod_pkg.sv
package ipod_pkg;

  // ==============================
  // Flash and sample widths
  // ==============================
  localparam int flash_addr_w = 23;
  localparam int flash_data_w = 32;
  localparam int sample_w     = 16;
  localparam int audio_w      = 8;

  // Last word address of the song image
  localparam logic [flash_addr_w-1:0] song_last_word = 23'h7FFFF;

  // Sample buffer geometry
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // ==============================
  // Sample period divisor
  // ==============================
  // One tick every divisor+1 cycles, 2267 is about 22 kHz at 50 MHz
  localparam int div_w = 16;
  localparam logic [div_w-1:0] div_default = 16'd2267;
  localparam logic [div_w-1:0] div_step    = 16'd100;
  localparam logic [div_w-1:0] div_min     = 16'd467;
  localparam logic [div_w-1:0] div_max     = 16'd4967;

  // Flash port, request side
  typedef struct packed {
    logic                    read;
    logic [flash_addr_w-1:0] address;
  } flash_req_t;

  // Flash port, response side
  typedef struct packed {
    logic                    waitrequest;
    logic                    readdatavalid;
    logic [flash_data_w-1:0] readdata;
  } flash_rsp_t;

  // Speed pulses
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_cmd_t;

endpackage

//--- hw/ipod_top.sv
`timescale 1ns/1ps

module ipod_top (
  input  logic                         CLK_50M,
  input  logic                         reset,
  input  logic                         play,
  input  logic                         direction,
  input  logic                         restart,
  input  ipod_pkg::speed_cmd_t         speed,
  input  ipod_pkg::flash_rsp_t         flash_rsp,
  output ipod_pkg::flash_req_t         flash_req,
  output logic [ipod_pkg::audio_w-1:0] audio,
  output logic                         sample_strobe,
  output logic [ipod_pkg::div_w-1:0]   divisor
);

  import ipod_pkg::*;

  // Producer to buffer
  logic                push;
  logic [sample_w-1:0] push_sample;
  logic                word_room;

  // Buffer to consumer
  logic                pop;
  logic [sample_w-1:0] head_sample;
  logic                empty;

  flash_fetch i_fetch (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .play        (play),
    .direction   (direction),
    .restart     (restart),
    .flash_req   (flash_req),
    .flash_rsp   (flash_rsp),
    .word_room   (word_room),
    .push        (push),
    .push_sample (push_sample)
  );

  // Restart also empties the buffer
  sample_fifo i_fifo (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .flush       (restart),
    .push        (push),
    .push_sample (push_sample),
    .pop         (pop),
    .head_sample (head_sample),
    .empty       (empty),
    .word_room   (word_room)
  );

  rate_control i_rate (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .speed   (speed),
    .divisor (divisor)
  );

  sample_player i_player (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .play          (play),
    .divisor       (divisor),
    .empty         (empty),
    .head_sample   (head_sample),
    .pop           (pop),
    .audio         (audio),
    .sample_strobe (sample_strobe)
  );

endmodule

//--- hw/rate_control.sv
`timescale 1ns/1ps

module rate_control (
  input  logic                       CLK_50M,
  input  logic                       reset,
  input  ipod_pkg::speed_cmd_t       speed,
  output logic [ipod_pkg::div_w-1:0] divisor
);

  import ipod_pkg::*;

  logic [div_w-1:0] div_faster;
  logic [div_w-1:0] div_slower;

  // ==============================
  // Stepped values with clamping
  // ==============================
  // Faster play means a shorter period
  always_comb
  begin
    if (divisor < div_min + div_step)
      div_faster = div_min;
    else
      div_faster = divisor - div_step;
  end

  always_comb
  begin
    if (divisor > div_max - div_step)
      div_slower = div_max;
    else
      div_slower = divisor + div_step;
  end

  // Speed reset first, then up, then down
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      divisor <= div_default;
    else if (speed.reset)
      divisor <= div_default;
    else if (speed.up)
      divisor <= div_faster;
    else if (speed.down)
      divisor <= div_slower;
  end

endmodule

//--- hw/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          push,
  input  logic [ipod_pkg::sample_w-1:0] push_sample,
  input  logic                          pop,
  output logic [ipod_pkg::sample_w-1:0] head_sample,
  output logic                          empty,
  output logic                          word_room
);

  import ipod_pkg::*;

  logic [sample_w-1:0]   mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push && (count != fifo_depth);
  assign do_pop  = pop && !empty;

  assign empty       = (count == 0);
  // Room for both halves of one flash word
  assign word_room   = (count <= fifo_depth - 2);
  assign head_sample = mem[rd_ptr];

  always_ff @(posedge CLK_50M)
  begin
    if (reset || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sample storage
  always_ff @(posedge CLK_50M)
  begin
    if (do_push && !flush)
      mem[wr_ptr] <= push_sample;
  end

endmodule

//--- hw/sample_player.sv
`timescale 1ns/1ps

module sample_player (
  input  logic                          CLK_50M,
  input  logic                          reset,
  input  logic                          play,
  input  logic [ipod_pkg::div_w-1:0]    divisor,
  input  logic                          empty,
  input  logic [ipod_pkg::sample_w-1:0] head_sample,
  output logic                          pop,
  output logic [ipod_pkg::audio_w-1:0]  audio,
  output logic                          sample_strobe
);

  import ipod_pkg::*;

  logic [div_w-1:0] phase;
  logic             tick;

  // >= keeps the period sane when the divisor drops below the phase
  assign tick = play && (phase >= divisor);
  // Underrun ticks pop nothing
  assign pop  = tick && !empty;

  // Sample period counter, frozen while paused
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      phase <= '0;
    else if (play)
      phase <= (phase >= divisor) ? '0 : phase + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      audio         <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= pop;
      if (pop)
        audio <= head_sample[sample_w-1:sample_w-audio_w];
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the tb_ipod simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ipod -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_ipod)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
exit 1

//--- tb/tb_ipod.sv
`timescale 1ns/1ps

module tb_ipod;

  import ipod_pkg::*;

  // About 25 strobes at the default rate plus the 20,000-cycle pause,
  // with a wide margin for flash latency and restarts
  localparam int max_cycles = 400000;

  localparam speed_cmd_t cmd_up    = '{up: 1'b1, down: 1'b0, reset: 1'b0};
  localparam speed_cmd_t cmd_reset = '{up: 1'b0, down: 1'b0, reset: 1'b1};

  logic               CLK_50M = 1'b0;
  logic               reset;
  logic               play;
  logic               direction;
  logic               restart;
  speed_cmd_t         speed;
  flash_rsp_t         flash_rsp;
  flash_req_t         flash_req;
  logic [audio_w-1:0] audio;
  logic               sample_strobe;
  logic [div_w-1:0]   divisor;

  int pass_count  = 0;
  int fail_count  = 0;
  int cycle_count = 0;

  // Flash model state
  logic [15:0]             lfsr;
  flash_req_t              seen_req;
  logic                    accepted;
  logic                    stalled;
  logic                    busy;
  int                      latency_left;
  int                      latency_draw;
  int                      waits_left;
  logic [flash_addr_w-1:0] pending_addr;

  // Expected sample order
  logic [flash_addr_w-1:0] ref_addr;
  logic                    ref_dir;
  logic                    ref_second;

  // Expected address of the next flash read
  logic [flash_addr_w-1:0] fetch_addr;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top i_dut (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .play          (play),
    .direction     (direction),
    .restart       (restart),
    .speed         (speed),
    .flash_rsp     (flash_rsp),
    .flash_req     (flash_req),
    .audio         (audio),
    .sample_strobe (sample_strobe),
    .divisor       (divisor)
  );

  bind ipod_top tb_ipod_asserts i_asserts (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .play          (play),
    .flash_req     (flash_req),
    .flash_rsp     (flash_rsp),
    .sample_strobe (sample_strobe),
    .divisor       (divisor)
  );

  // Watchdog
  always @(posedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ==============================
  // Helpers
  // ==============================
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output int value);
    int i;
    value = 0;
    for (i = 0; i < n; i++)
    begin
      lfsr  = lfsr_step(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  // Lower half is the address, upper half the address XOR A5A5
  function automatic logic [flash_data_w-1:0] flash_word(input logic [flash_addr_w-1:0] addr);
    return {addr[15:0] ^ 16'hA5A5, addr[15:0]};
  endfunction

  // One word along the song, wrapping at both ends
  function automatic logic [flash_addr_w-1:0] step_addr(input logic [flash_addr_w-1:0] addr,
                                                        input logic dir);
    if (dir)
      return (addr == '0) ? song_last_word : addr - 1'b1;
    else
      return (addr == song_last_word) ? '0 : addr + 1'b1;
  endfunction

  task automatic ref_restart(input logic dir);
    ref_dir    = dir;
    ref_addr   = dir ? song_last_word : '0;
    ref_second = 1'b0;
    fetch_addr = ref_addr;
  endtask

  task automatic ref_next(output logic [audio_w-1:0] expected);
    logic [flash_data_w-1:0] word;
    logic                    take_upper;
    logic [15:0]             half;
    word       = flash_word(ref_addr);
    take_upper = ref_second ? !ref_dir : ref_dir;
    half       = take_upper ? word[31:16] : word[15:0];
    expected   = half[15:8];
    if (ref_second)
      ref_addr = step_addr(ref_addr, ref_dir);
    ref_second = !ref_second;
  endtask

  task automatic check_audio(input string name, input logic [audio_w-1:0] expected,
                             input logic [audio_w-1:0] actual);
    if (actual === expected)
      pass_count++;
    else
    begin
      fail_count++;
      $display("ERROR %s: audio expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic check_divisor(input string name, input logic [div_w-1:0] expected,
                               input logic [div_w-1:0] actual);
    if (actual === expected)
      pass_count++;
    else
    begin
      fail_count++;
      $display("ERROR %s: divisor expected %0d, got %0d", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual === expected)
      pass_count++;
    else
    begin
      fail_count++;
      $display("ERROR %s: flag expected %b, got %b", name, expected, actual);
    end
  endtask

  task automatic check_address(input string name, input logic [flash_addr_w-1:0] expected,
                               input logic [flash_addr_w-1:0] actual);
    if (actual === expected)
      pass_count++;
    else
    begin
      fail_count++;
      $display("ERROR %s: address expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("test %s finished with %0d errors", name, fail_count - fails_before);
  endtask

  task automatic next_cycle();
    @(posedge CLK_50M);
    #2;
  endtask

  // Cycles counted from the call to the strobe
  task automatic wait_strobe(output logic [div_w-1:0] gap);
    gap = '0;
    do
    begin
      @(negedge CLK_50M);
      gap = gap + 1'b1;
    end
    while (!sample_strobe);
  endtask

  task automatic expect_sample(input string name, output logic [div_w-1:0] gap);
    logic [audio_w-1:0] expected;
    wait_strobe(gap);
    ref_next(expected);
    check_audio(name, expected, audio);
  endtask

  task automatic pulse_speed(input speed_cmd_t cmd);
    speed = cmd;
    next_cycle();
    speed = '0;
    next_cycle();
  endtask

  // ==============================
  // Flash model
  // ==============================
  initial
  begin : flash_model
    lfsr      = 16'd56;
    busy      = 1'b0;
    flash_rsp = '0;
    draw_bits(2, waits_left);
    flash_rsp.waitrequest = (waits_left != 0);
    forever
    begin
      @(negedge CLK_50M);
      seen_req = flash_req;
      accepted = seen_req.read && !flash_rsp.waitrequest;
      stalled  = seen_req.read && flash_rsp.waitrequest;
      @(posedge CLK_50M);
      #2;
      flash_rsp.readdatavalid = 1'b0;
      if (busy)
      begin
        if (latency_left == 1)
        begin
          flash_rsp.readdatavalid = 1'b1;
          flash_rsp.readdata      = flash_word(pending_addr);
          busy                    = 1'b0;
        end
        else
          latency_left = latency_left - 1;
      end
      if (accepted)
      begin
        check_address("flash_address", fetch_addr, seen_req.address);
        fetch_addr   = step_addr(fetch_addr, ref_dir);
        busy         = 1'b1;
        pending_addr = seen_req.address;
        draw_bits(2, latency_draw);
        latency_left = 3 + latency_draw;
        // Stall length for the next request
        draw_bits(2, waits_left);
        flash_rsp.waitrequest = (waits_left != 0);
      end
      else if (stalled)
      begin
        waits_left            = waits_left - 1;
        flash_rsp.waitrequest = (waits_left != 0);
      end
    end
  end

  // ==============================
  // Tests
  // ==============================
  task automatic test_reset_state();
    int   fails_before;
    logic seen;
    fails_before = fail_count;
    seen         = 1'b0;
    repeat (50)
    begin
      @(negedge CLK_50M);
      if (sample_strobe || flash_req.read)
        seen = 1'b1;
    end
    check_divisor("reset_state", div_default, divisor);
    check_flag("reset_state", 1'b0, seen);
    report_test("reset_state", fails_before);
  endtask

  task automatic test_forward_play();
    int               fails_before;
    logic [div_w-1:0] gap;
    fails_before = fail_count;
    next_cycle();
    direction = 1'b0;
    restart   = 1'b1;
    next_cycle();
    restart = 1'b0;
    play    = 1'b1;
    ref_restart(1'b0);
    repeat (12)
      expect_sample("forward_play", gap);
    report_test("forward_play", fails_before);
  endtask

  task automatic test_backward_play();
    int               fails_before;
    logic [div_w-1:0] gap;
    fails_before = fail_count;
    // Stop right after a strobe so no pop is in flight
    next_cycle();
    play = 1'b0;
    repeat (20)
      next_cycle();
    direction = 1'b1;
    restart   = 1'b1;
    next_cycle();
    restart = 1'b0;
    play    = 1'b1;
    ref_restart(1'b1);
    repeat (4)
      expect_sample("backward_play", gap);
    report_test("backward_play", fails_before);
  endtask

  task automatic test_pause_resume();
    int               fails_before;
    logic [div_w-1:0] gap;
    logic             seen;
    fails_before = fail_count;
    expect_sample("pause_resume", gap);
    next_cycle();
    play = 1'b0;
    seen = 1'b0;
    repeat (20000)
    begin
      @(negedge CLK_50M);
      if (sample_strobe)
        seen = 1'b1;
    end
    check_flag("pause_resume", 1'b0, seen);
    next_cycle();
    play = 1'b1;
    repeat (4)
      expect_sample("pause_resume", gap);
    report_test("pause_resume", fails_before);
  endtask

  task automatic test_speed_rule();
    int               fails_before;
    logic [div_w-1:0] gap;
    fails_before = fail_count;
    next_cycle();
    play = 1'b0;
    repeat (3)
      pulse_speed(cmd_up);
    @(negedge CLK_50M);
    check_divisor("speed_rule", div_default - div_step - div_step - div_step, divisor);
    next_cycle();
    pulse_speed(cmd_reset);
    @(negedge CLK_50M);
    check_divisor("speed_rule", div_default, divisor);
    next_cycle();
    // 18 steps reach the floor, two more must clamp
    repeat (20)
      pulse_speed(cmd_up);
    @(negedge CLK_50M);
    check_divisor("speed_rule", div_min, divisor);
    next_cycle();
    play = 1'b1;
    repeat (2)
      expect_sample("speed_rule", gap);
    repeat (2)
    begin
      expect_sample("speed_rule", gap);
      check_divisor("speed_rule", div_min + 16'd1, gap);
    end
    report_test("speed_rule", fails_before);
  endtask

  initial
  begin
    reset     = 1'b1;
    play      = 1'b0;
    direction = 1'b0;
    restart   = 1'b0;
    speed     = '0;
    repeat (5) @(posedge CLK_50M);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_forward_play();
    test_backward_play();
    test_pause_resume();
    test_speed_rule();
    $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tb/tb_ipod_asserts.sv
`timescale 1ns/1ps

module tb_ipod_asserts (
  input logic                       CLK_50M,
  input logic                       reset,
  input logic                       play,
  input ipod_pkg::flash_req_t       flash_req,
  input ipod_pkg::flash_rsp_t       flash_rsp,
  input logic                       sample_strobe,
  input logic [ipod_pkg::div_w-1:0] divisor
);

  import ipod_pkg::*;

  // ==============================
  // Flash port
  // ==============================
  // A stalled request keeps read and address
  a_req_held: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
    else $error("flash request changed while waitrequest was high");

  // No sample leaves while paused
  a_strobe_play: assert property (@(posedge CLK_50M) disable iff (reset)
    sample_strobe |-> play)
    else $error("sample_strobe without play");

  a_div_range: assert property (@(posedge CLK_50M) disable iff (reset)
    divisor >= div_min && divisor <= div_max)
    else $error("divisor outside its limits");

endmodule
